/* src/regfile_config.svh */
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// register word width
`define REGFILE_XLEN 32

// architectural registers, x0 included
`define REGFILE_NUM_REGS 32

// register index width
`define REGFILE_IDX_W 5

// debug byte address width, index = addr / 4
`define REGFILE_AXIL_ADDR_W 7

`endif

/* src/regfile_pkg.sv */
`include "regfile_config.svh"

package regfile_pkg;

    typedef logic [`REGFILE_IDX_W-1:0] reg_idx_t;
    typedef logic [`REGFILE_XLEN-1:0] reg_data_t;
    typedef logic [`REGFILE_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

    // write-back request, idx 0 means no write
    typedef struct packed {
        reg_idx_t  idx;
        reg_data_t data;
    } wb_req_t;

    // source indices of one issue slot
    typedef struct packed {
        reg_idx_t ra;
        reg_idx_t rb;
    } src_idx_t;

    // operand values of one issue slot
    typedef struct packed {
        reg_data_t a;
        reg_data_t b;
    } src_val_t;

    // debug write into the array
    typedef struct packed {
        logic      valid;
        reg_idx_t  idx;
        reg_data_t data;
    } dbg_wr_t;

    //----------------------------------------------------------------------
    // AXI4-Lite, no byte strobes
    //----------------------------------------------------------------------
    typedef struct packed {
        logic       aw_valid;
        axil_addr_t aw_addr;
        logic       w_valid;
        reg_data_t  w_data;
        logic       b_ready;
        logic       ar_valid;
        axil_addr_t ar_addr;
        logic       r_ready;
    } axil_req_t;

    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        axil_resp_t b_resp;
        logic       ar_ready;
        logic       r_valid;
        reg_data_t  r_data;
        axil_resp_t r_resp;
    } axil_rsp_t;

endpackage

/* src/regfile_array.sv */
`include "regfile_config.svh"

module regfile_array
    import regfile_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // write-back ports, port 0 has priority
    input  wb_req_t   wb0_i,
    input  wb_req_t   wb1_i,

    // debug write, lowest priority
    input  dbg_wr_t   dbg_wr_i,

    // operand indices, two per issue slot
    input  src_idx_t  src0_i,
    input  src_idx_t  src1_i,

    input  reg_idx_t  dbg_rd_idx_i,

    output src_val_t  src0_o,
    output src_val_t  src1_o,
    output reg_data_t dbg_rd_data_o
);

    //----------------------------------------------------------------------
    // storage, x1 to x31
    //----------------------------------------------------------------------
    reg_data_t regs_q [1:`REGFILE_NUM_REGS-1];

    // read view with x0 tied to zero
    reg_data_t rd_view [0:`REGFILE_NUM_REGS-1];

    for (genvar r = 1; r < `REGFILE_NUM_REGS; r++)
    begin : g_reg
        logic sel_wb0;
        logic sel_wb1;
        logic sel_dbg;

        // write select per register
        assign sel_wb0 = (wb0_i.idx == reg_idx_t'(r));
        assign sel_wb1 = (wb1_i.idx == reg_idx_t'(r));
        assign sel_dbg = dbg_wr_i.valid && (dbg_wr_i.idx == reg_idx_t'(r));

        always_ff @(posedge clk_i or posedge rst_i)
        begin
            if (rst_i)
            begin
                regs_q[r] <= '0;
            end
            else if (sel_wb0)
            begin
                regs_q[r] <= wb0_i.data;
            end
            else if (sel_wb1)
            begin
                regs_q[r] <= wb1_i.data;
            end
            else if (sel_dbg)
            begin
                // only lands when neither write-back port wants this register
                regs_q[r] <= dbg_wr_i.data;
            end
        end

        assign rd_view[r] = regs_q[r];
    end

    assign rd_view[0] = '0;

    //----------------------------------------------------------------------
    // combinational read ports
    //----------------------------------------------------------------------
    // no bypass, a same-cycle write shows up next cycle
    always_comb
    begin
        src0_o.a      = rd_view[src0_i.ra];
        src0_o.b      = rd_view[src0_i.rb];
        src1_o.a      = rd_view[src1_i.ra];
        src1_o.b      = rd_view[src1_i.rb];
        dbg_rd_data_o = rd_view[dbg_rd_idx_i];
    end

endmodule

/* src/regfile_debug_axil.sv */
`include "regfile_config.svh"

module regfile_debug_axil
    import regfile_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // bus side
    input  axil_req_t axil_i,
    output axil_rsp_t axil_o,

    // register array side
    output dbg_wr_t   dbg_wr_o,
    output reg_idx_t  dbg_rd_idx_o,
    input  reg_data_t dbg_rd_data_i
);

    logic      wr_accept;
    logic      rd_accept;
    logic      b_valid_q;
    logic      r_valid_q;
    reg_data_t r_data_q;

    //----------------------------------------------------------------------
    // write channel
    //----------------------------------------------------------------------
    // address and data taken together, only once the last B is gone
    assign wr_accept = axil_i.aw_valid && axil_i.w_valid && !b_valid_q;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            b_valid_q <= 1'b0;
        end
        else if (wr_accept)
        begin
            b_valid_q <= 1'b1;
        end
        else if (axil_i.b_ready)
        begin
            b_valid_q <= 1'b0;
        end
    end

    // one-cycle write pulse, word index above the byte offset
    always_comb
    begin
        dbg_wr_o.valid = wr_accept;
        dbg_wr_o.idx   = axil_i.aw_addr[`REGFILE_AXIL_ADDR_W-1:2];
        dbg_wr_o.data  = axil_i.w_data;
    end

    //----------------------------------------------------------------------
    // read channel
    //----------------------------------------------------------------------
    assign rd_accept = axil_i.ar_valid && !r_valid_q;

    // array read is combinational, so the index comes straight off AR
    assign dbg_rd_idx_o = axil_i.ar_addr[`REGFILE_AXIL_ADDR_W-1:2];

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            r_valid_q <= 1'b0;
        end
        else if (rd_accept)
        begin
            r_valid_q <= 1'b1;
        end
        else if (axil_i.r_ready)
        begin
            r_valid_q <= 1'b0;
        end
    end

    // held stable while r_valid waits
    always_ff @(posedge clk_i)
    begin
        if (rd_accept)
        begin
            r_data_q <= dbg_rd_data_i;
        end
    end

    //----------------------------------------------------------------------
    // response outputs
    //----------------------------------------------------------------------
    always_comb
    begin
        axil_o.aw_ready = wr_accept;
        axil_o.w_ready  = wr_accept;
        axil_o.b_valid  = b_valid_q;
        axil_o.b_resp   = AXIL_RESP_OKAY;
        axil_o.ar_ready = !r_valid_q;
        axil_o.r_valid  = r_valid_q;
        axil_o.r_data   = r_data_q;
        axil_o.r_resp   = AXIL_RESP_OKAY;
    end

endmodule

/* src/regfile_top.sv */
`include "regfile_config.svh"

module regfile_top
    import regfile_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // write-back from both issue slots
    input  wb_req_t   wb0_i,
    input  wb_req_t   wb1_i,

    // operand reads
    input  src_idx_t  src0_i,
    input  src_idx_t  src1_i,
    output src_val_t  src0_o,
    output src_val_t  src1_o,

    // debug access
    input  axil_req_t axil_i,
    output axil_rsp_t axil_o
);

    dbg_wr_t   dbg_wr;
    reg_idx_t  dbg_rd_idx;
    reg_data_t dbg_rd_data;

    //----------------------------------------------------------------------
    // register storage
    //----------------------------------------------------------------------
    regfile_array i_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wb0_i         (wb0_i),
        .wb1_i         (wb1_i),
        .dbg_wr_i      (dbg_wr),
        .src0_i        (src0_i),
        .src1_i        (src1_i),
        .dbg_rd_idx_i  (dbg_rd_idx),
        .src0_o        (src0_o),
        .src1_o        (src1_o),
        .dbg_rd_data_o (dbg_rd_data)
    );

    //----------------------------------------------------------------------
    // debug bus slave
    //----------------------------------------------------------------------
    regfile_debug_axil i_debug (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .axil_i        (axil_i),
        .axil_o        (axil_o),
        .dbg_wr_o      (dbg_wr),
        .dbg_rd_idx_o  (dbg_rd_idx),
        .dbg_rd_data_i (dbg_rd_data)
    );

endmodule

/* bench/regfile_tb.sv */
`include "regfile_config.svh"

module regfile_tb
    import regfile_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_STEPS    = 16;
    localparam int          MAX_STALL    = 4;
    localparam int          TIMEOUT_NS   = (RESET_CYCLES + 20 * NUM_STEPS) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED    = 32'h1be2_c7cb;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    typedef enum logic [2:0] {OP_WB, OP_RD, OP_DBG_WR, OP_DBG_RD, OP_COLL} op_t;

    typedef struct packed {
        op_t       op;
        reg_idx_t  idx0;
        reg_data_t data0;
        reg_idx_t  idx1;
        reg_data_t data1;
        reg_idx_t  dbg_idx;
        reg_data_t dbg_data;
        reg_data_t exp_old;
        reg_data_t exp0;
        reg_data_t exp1;
    } step_t;

    logic        clk_i;
    logic        rst_i;
    wb_req_t     wb0_i;
    wb_req_t     wb1_i;
    src_idx_t    src0_i;
    src_idx_t    src1_i;
    src_val_t    src0_o;
    src_val_t    src1_o;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] lfsr_state;

    //----------------------------------------------------------------------
    // stimulus table
    //----------------------------------------------------------------------
    // op, wb0 idx/data, wb1 idx/data, debug idx/data, old, exp0, exp1
    step_t steps [NUM_STEPS] = '{
        '{OP_WB, 5'd5, 32'h1111_0005, 5'd9, 32'h2222_0009, 5'd0, 32'h0,
          32'h0, 32'h1111_0005, 32'h2222_0009},
        '{OP_WB, 5'd0, 32'hdead_0000, 5'd3, 32'h3333_0003, 5'd0, 32'h0,
          32'h0, 32'h0, 32'h3333_0003},
        // same destination on both ports
        '{OP_WB, 5'd7, 32'h4444_0007, 5'd7, 32'h5555_0007, 5'd0, 32'h0,
          32'h0, 32'h4444_0007, 32'h4444_0007},
        '{OP_WB, 5'd7, 32'h6666_0007, 5'd0, 32'hdead_beef, 5'd0, 32'h0,
          32'h4444_0007, 32'h6666_0007, 32'h0},
        '{OP_RD, 5'd5, 32'h0, 5'd9, 32'h0, 5'd0, 32'h0,
          32'h0, 32'h1111_0005, 32'h2222_0009},
        '{OP_DBG_WR, 5'd0, 32'h0, 5'd0, 32'h0, 5'd12, 32'hc0de_000c,
          32'h0, 32'hc0de_000c, 32'h0},
        '{OP_DBG_RD, 5'd0, 32'h0, 5'd0, 32'h0, 5'd12, 32'h0,
          32'h0, 32'hc0de_000c, 32'h0},
        '{OP_DBG_RD, 5'd0, 32'h0, 5'd0, 32'h0, 5'd0, 32'h0,
          32'h0, 32'h0, 32'h0},
        '{OP_DBG_RD, 5'd0, 32'h0, 5'd0, 32'h0, 5'd5, 32'h0,
          32'h0, 32'h1111_0005, 32'h0},
        // x0 ignores a debug write
        '{OP_DBG_WR, 5'd0, 32'h0, 5'd0, 32'h0, 5'd0, 32'hffff_ffff,
          32'h0, 32'h0, 32'h0},
        '{OP_COLL, 5'd12, 32'h7777_000c, 5'd0, 32'h0, 5'd12, 32'hbad0_000c,
          32'h0, 32'h7777_000c, 32'h0},
        '{OP_COLL, 5'd0, 32'h0, 5'd20, 32'h8888_0014, 5'd20, 32'hbad0_0014,
          32'h0, 32'h8888_0014, 32'h0},
        '{OP_DBG_WR, 5'd0, 32'h0, 5'd0, 32'h0, 5'd31, 32'h9999_001f,
          32'h0, 32'h9999_001f, 32'h0},
        '{OP_DBG_RD, 5'd0, 32'h0, 5'd0, 32'h0, 5'd31, 32'h0,
          32'h0, 32'h9999_001f, 32'h0},
        '{OP_RD, 5'd12, 32'h0, 5'd20, 32'h0, 5'd0, 32'h0,
          32'h0, 32'h7777_000c, 32'h8888_0014},
        '{OP_DBG_RD, 5'd0, 32'h0, 5'd0, 32'h0, 5'd7, 32'h0,
          32'h0, 32'h6666_0007, 32'h0}
    };

    regfile_top i_dut (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .wb0_i  (wb0_i),
        .wb1_i  (wb1_i),
        .src0_i (src0_i),
        .src1_i (src1_i),
        .src0_o (src0_o),
        .src1_o (src1_o),
        .axil_i (axil_req),
        .axil_o (axil_rsp)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("ERROR: timeout, the run hung waiting for the DUT");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic next_random_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // called at a falling edge with a on src0.a and src1.b
    task automatic read_pair(input reg_idx_t a, input reg_idx_t b,
                             input reg_data_t exp_a, input reg_data_t exp_b);
        src0_i = '{ra: a, rb: b};
        src1_i = '{ra: b, rb: a};
        #1;
        check_value("src0_o.a", exp_a, src0_o.a);
        check_value("src0_o.b", exp_b, src0_o.b);
        check_value("src1_o.a", exp_b, src1_o.a);
        check_value("src1_o.b", exp_a, src1_o.b);
    endtask

    task automatic run_writeback(input step_t row);
        @(negedge clk_i);
        wb0_i = '{idx: row.idx0, data: row.data0};
        wb1_i = '{idx: row.idx1, data: row.data1};
        src0_i = '{ra: row.idx0, rb: row.idx1};
        src1_i = '{ra: row.idx1, rb: row.idx0};
        #1;
        // no bypass so still the old value
        check_value("src0_o.a", row.exp_old, src0_o.a);
        @(negedge clk_i);
        wb0_i = '0;
        wb1_i = '0;
        read_pair(row.idx0, row.idx1, row.exp0, row.exp1);
        @(negedge clk_i);
        read_pair(row.idx1, row.idx0, row.exp1, row.exp0);
    endtask

    // write-backs ride along with the accepting cycle
    task automatic write_debug(input reg_idx_t idx, input reg_data_t data,
                               input wb_req_t wb0, input wb_req_t wb1);
        logic rdy;
        int   stalls;
        stalls = 0;
        @(negedge clk_i);
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = {idx, 2'b00};
        axil_req.w_valid  = 1'b1;
        axil_req.w_data   = data;
        axil_req.b_ready  = 1'b0;
        wb0_i = wb0;
        wb1_i = wb1;
        #1;
        while (!axil_rsp.aw_ready)
        begin
            @(negedge clk_i);
            #1;
        end
        check_value("axil_o.w_ready", 32'h1, 32'(axil_rsp.w_ready));
        @(negedge clk_i);
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        wb0_i = '0;
        wb1_i = '0;
        // response with random b_ready stalls
        forever
        begin
            check_value("axil_o.b_valid", 32'h1, 32'(axil_rsp.b_valid));
            check_value("axil_o.b_resp", 32'(AXIL_RESP_OKAY), 32'(axil_rsp.b_resp));
            next_random_bit(rdy);
            if (stalls >= MAX_STALL)
            begin
                rdy = 1'b1;
            end
            stalls = stalls + 1;
            axil_req.b_ready = rdy;
            @(negedge clk_i);
            if (rdy)
            begin
                break;
            end
        end
        axil_req.b_ready = 1'b0;
        check_value("axil_o.b_valid", 32'h0, 32'(axil_rsp.b_valid));
        @(negedge clk_i);
        check_value("axil_o.b_valid", 32'h0, 32'(axil_rsp.b_valid));
    endtask

    task automatic read_debug(input reg_idx_t idx, input reg_data_t exp);
        logic rdy;
        int   stalls;
        stalls = 0;
        @(negedge clk_i);
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = {idx, 2'b00};
        axil_req.r_ready  = 1'b0;
        #1;
        while (!axil_rsp.ar_ready)
        begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        axil_req.ar_valid = 1'b0;
        // r_data must hold while r_ready is low
        forever
        begin
            check_value("axil_o.r_valid", 32'h1, 32'(axil_rsp.r_valid));
            check_value("axil_o.ar_ready", 32'h0, 32'(axil_rsp.ar_ready));
            check_value("axil_o.r_data", exp, axil_rsp.r_data);
            check_value("axil_o.r_resp", 32'(AXIL_RESP_OKAY), 32'(axil_rsp.r_resp));
            next_random_bit(rdy);
            if (stalls >= MAX_STALL)
            begin
                rdy = 1'b1;
            end
            stalls = stalls + 1;
            axil_req.r_ready = rdy;
            @(negedge clk_i);
            if (rdy)
            begin
                break;
            end
        end
        axil_req.r_ready = 1'b0;
        check_value("axil_o.r_valid", 32'h0, 32'(axil_rsp.r_valid));
        check_value("axil_o.ar_ready", 32'h1, 32'(axil_rsp.ar_ready));
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial
    begin : stimulus
        step_t row;
        rst_i      = 1'b1;
        wb0_i      = '0;
        wb1_i      = '0;
        src0_i     = '0;
        src1_i     = '0;
        axil_req   = '0;
        lfsr_state = LFSR_SEED;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        #1;
        check_value("axil_o.b_valid", 32'h0, 32'(axil_rsp.b_valid));
        check_value("axil_o.r_valid", 32'h0, 32'(axil_rsp.r_valid));
        check_value("axil_o.aw_ready", 32'h0, 32'(axil_rsp.aw_ready));
        check_value("axil_o.ar_ready", 32'h1, 32'(axil_rsp.ar_ready));

        // every index reads zero after reset
        for (int i = 0; i < `REGFILE_NUM_REGS; i++)
        begin
            @(negedge clk_i);
            read_pair(reg_idx_t'(i), reg_idx_t'(`REGFILE_NUM_REGS - 1 - i), '0, '0);
        end

        for (int s = 0; s < NUM_STEPS; s++)
        begin
            row = steps[s];
            case (row.op)
                OP_WB:
                begin
                    run_writeback(row);
                end
                OP_RD:
                begin
                    @(negedge clk_i);
                    read_pair(row.idx0, row.idx1, row.exp0, row.exp1);
                end
                OP_DBG_WR:
                begin
                    write_debug(row.dbg_idx, row.dbg_data, '0, '0);
                    read_pair(row.dbg_idx, row.dbg_idx, row.exp0, row.exp0);
                end
                OP_DBG_RD:
                begin
                    read_debug(row.dbg_idx, row.exp0);
                end
                OP_COLL:
                begin
                    write_debug(row.dbg_idx, row.dbg_data,
                                '{idx: row.idx0, data: row.data0},
                                '{idx: row.idx1, data: row.data1});
                    read_pair(row.dbg_idx, row.dbg_idx, row.exp0, row.exp0);
                end
                default:
                begin
                    $display("ERROR: unknown operation in stimulus table row %0d", s);
                    $display("FAIL: see errors above");
                    $fatal(1);
                end
            endcase
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/regfile_pkg.sv
src/regfile_array.sv
src/regfile_debug_axil.sv
src/regfile_top.sv
bench/regfile_tb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --timing --assert --timescale 1ns/100ps
TOP       := regfile_tb
RTL_TOP   := regfile_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
